// ==== verilog/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    localparam logic [31:0] reset_vector = 32'hbfc0_0000;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_jalr = 6'h09,
        fn_addu = 6'h21,
        fn_subu = 6'h23
    } funct_e;

    // branch kind lives in the rt field under op_regimm
    typedef enum logic [4:0] {
        rt_bltz   = 5'h00,
        rt_bgez   = 5'h01,
        rt_bltzal = 5'h10,
        rt_bgezal = 5'h11
    } regimm_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        funct_e      funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        j_type_t j;
    } instr_t;

endpackage

`default_nettype wire

// ==== verilog/mips_core_pkg.sv ====
`default_nettype none

package mips_core_pkg;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_exec,
        st_mem,
        st_mem_wait
    } ctrl_state_e;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic rs_eq_rt;
        logic rs_gtz;
        logic rs_eqz;
        logic rs_ltz;
    } branch_flags_t;

    typedef enum logic [2:0] {
        pc_seq,
        pc_jump_abs,
        pc_jump_reg,
        pc_branch,
        pc_branch_link,
        pc_jump_link,
        pc_jump_reg_link
    } pc_op_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        cond_eq,
        cond_ne,
        cond_gtz,
        cond_lez,
        cond_ltz,
        cond_gez
    } branch_cond_e;

    typedef struct packed {
        pc_op_e       pc_op;
        branch_cond_e branch_cond;
        alu_op_e      alu_op;
        logic         use_imm;
        logic         reg_write;
        logic [4:0]   write_reg;
        logic         is_load;
        logic         is_store;
        logic         is_link;
    } dec_t;

endpackage

`default_nettype wire

// ==== verilog/mips_cpu_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_pc (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        advance,
    input  wire mips_isa_pkg::instr_t        instr,
    input  wire mips_core_pkg::pc_op_e       pc_op,
    input  wire mips_core_pkg::branch_cond_e branch_cond,
    input  wire mips_core_pkg::branch_flags_t flags,
    input  wire logic [31:0]                 rs_data,
    output logic [31:0]                      pc,
    output logic [31:0]                      link_addr
);

    logic [31:0] pc_inc;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_dest;
    logic [31:0] dest;
    logic        delay_flag;
    logic        cond_true;
    logic        transfer;

    assign pc_inc        = pc + 32'd4; // delay slot address
    assign link_addr     = pc + 32'd8;
    assign branch_target = pc_inc + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jump_target   = {pc_inc[31:28], instr.j.target, 2'b00};

    always_comb begin
        case (branch_cond)
            mips_core_pkg::cond_eq:  cond_true = flags.rs_eq_rt;
            mips_core_pkg::cond_ne:  cond_true = !flags.rs_eq_rt;
            mips_core_pkg::cond_gtz: cond_true = flags.rs_gtz;
            mips_core_pkg::cond_lez: cond_true = flags.rs_eqz || flags.rs_ltz;
            mips_core_pkg::cond_ltz: cond_true = flags.rs_ltz;
            mips_core_pkg::cond_gez: cond_true = flags.rs_gtz || flags.rs_eqz;
            default:                 cond_true = 1'b0;
        endcase
    end

    always_comb begin
        transfer  = 1'b1;
        next_dest = jump_target;
        case (pc_op)
            mips_core_pkg::pc_jump_abs,
            mips_core_pkg::pc_jump_link: next_dest = jump_target;
            mips_core_pkg::pc_jump_reg,
            mips_core_pkg::pc_jump_reg_link: next_dest = rs_data;
            mips_core_pkg::pc_branch,
            mips_core_pkg::pc_branch_link: begin
                transfer  = cond_true; // link ops still write r31 when not taken
                next_dest = branch_target;
            end
            default: transfer = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= mips_isa_pkg::reset_vector;
            delay_flag <= 1'b0;
        end else if (advance) begin
            if (transfer) begin
                pc         <= pc_inc; // run the delay slot first
                delay_flag <= 1'b1;
            end else if (delay_flag) begin
                pc         <= dest;
                delay_flag <= 1'b0;
            end else begin
                pc <= pc_inc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && transfer) begin
            dest <= next_dest;
        end
    end

    // jr/jalr targets come straight from the register file
    pc_aligned_a: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_decode (
    input  wire mips_isa_pkg::instr_t instr,
    output mips_core_pkg::dec_t       dec
);

    always_comb begin
        dec.pc_op       = mips_core_pkg::pc_seq; // unknown encodings fall out as no-ops
        dec.branch_cond = mips_core_pkg::cond_eq;
        dec.alu_op      = mips_core_pkg::alu_add;
        dec.use_imm     = 1'b0;
        dec.reg_write   = 1'b0;
        dec.write_reg   = instr.r.rt;
        dec.is_load     = 1'b0;
        dec.is_store    = 1'b0;
        dec.is_link     = 1'b0;
        case (instr.r.opcode)
            mips_isa_pkg::op_special: begin
                dec.write_reg = instr.r.rd;
                case (instr.r.funct)
                    mips_isa_pkg::fn_addu: dec.reg_write = 1'b1;
                    mips_isa_pkg::fn_subu: begin
                        dec.alu_op    = mips_core_pkg::alu_sub;
                        dec.reg_write = 1'b1;
                    end
                    mips_isa_pkg::fn_jr: dec.pc_op = mips_core_pkg::pc_jump_reg;
                    mips_isa_pkg::fn_jalr: begin
                        dec.pc_op     = mips_core_pkg::pc_jump_reg_link;
                        dec.reg_write = 1'b1;
                        dec.is_link   = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            mips_isa_pkg::op_regimm: begin
                dec.pc_op     = mips_core_pkg::pc_branch;
                dec.write_reg = 5'd31;
                case (instr.i.rt)
                    mips_isa_pkg::rt_bltz:   dec.branch_cond = mips_core_pkg::cond_ltz;
                    mips_isa_pkg::rt_bgez:   dec.branch_cond = mips_core_pkg::cond_gez;
                    mips_isa_pkg::rt_bltzal: begin
                        dec.pc_op       = mips_core_pkg::pc_branch_link;
                        dec.branch_cond = mips_core_pkg::cond_ltz;
                        dec.reg_write   = 1'b1;
                        dec.is_link     = 1'b1;
                    end
                    mips_isa_pkg::rt_bgezal: begin
                        dec.pc_op       = mips_core_pkg::pc_branch_link;
                        dec.branch_cond = mips_core_pkg::cond_gez;
                        dec.reg_write   = 1'b1;
                        dec.is_link     = 1'b1;
                    end
                    default: dec.pc_op = mips_core_pkg::pc_seq;
                endcase
            end
            mips_isa_pkg::op_j: dec.pc_op = mips_core_pkg::pc_jump_abs;
            mips_isa_pkg::op_jal: begin
                dec.pc_op     = mips_core_pkg::pc_jump_link;
                dec.reg_write = 1'b1;
                dec.write_reg = 5'd31;
                dec.is_link   = 1'b1;
            end
            mips_isa_pkg::op_beq: dec.pc_op = mips_core_pkg::pc_branch;
            mips_isa_pkg::op_bne: begin
                dec.pc_op       = mips_core_pkg::pc_branch;
                dec.branch_cond = mips_core_pkg::cond_ne;
            end
            mips_isa_pkg::op_blez: begin
                dec.pc_op       = mips_core_pkg::pc_branch;
                dec.branch_cond = mips_core_pkg::cond_lez;
            end
            mips_isa_pkg::op_bgtz: begin
                dec.pc_op       = mips_core_pkg::pc_branch;
                dec.branch_cond = mips_core_pkg::cond_gtz;
            end
            mips_isa_pkg::op_addiu: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_isa_pkg::op_lui: begin
                dec.alu_op    = mips_core_pkg::alu_lui;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_isa_pkg::op_lw: begin
                dec.use_imm   = 1'b1; // base + offset
                dec.reg_write = 1'b1;
                dec.is_load   = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            default: dec.pc_op = mips_core_pkg::pc_seq;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_regfile (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  rs_addr,
    input  wire logic [4:0]  rt_addr,
    output logic [31:0]      rs_data,
    output logic [31:0]      rt_data,
    input  wire logic        we,
    input  wire logic [4:0]  wr_addr,
    input  wire logic [31:0] wr_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != 5'd0) begin // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // holds even after link or load writes aimed at r0
    r0_zero_a: assert property (@(posedge clk) disable iff (reset)
        (rs_addr == 5'd0) |-> (rs_data == 32'd0));

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_alu (
    input  wire mips_core_pkg::alu_op_e   alu_op,
    input  wire logic                     use_imm,
    input  wire logic [31:0]              rs_data,
    input  wire logic [31:0]              rt_data,
    input  wire logic [15:0]              imm,
    output logic [31:0]                   result,
    output mips_core_pkg::branch_flags_t  flags
);

    logic [31:0] imm_ext;
    logic [31:0] operand_b;

    assign imm_ext   = {{16{imm[15]}}, imm};
    assign operand_b = use_imm ? imm_ext : rt_data;

    always_comb begin
        case (alu_op)
            mips_core_pkg::alu_add: result = rs_data + operand_b; // also lw/sw address
            mips_core_pkg::alu_sub: result = rs_data - operand_b;
            mips_core_pkg::alu_lui: result = {imm, 16'h0000};
            default:                result = rs_data + operand_b;
        endcase
    end

    // signed compares for the branch unit
    assign flags.rs_eq_rt = rs_data == rt_data;
    assign flags.rs_gtz   = $signed(rs_data) > 32'sd0;
    assign flags.rs_eqz   = rs_data == 32'd0;
    assign flags.rs_ltz   = rs_data[31];

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_control (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire mips_core_pkg::dec_t  dec,
    input  wire logic [31:0]          alu_result,
    input  wire logic [31:0]          rt_data,
    input  wire logic [31:0]          link_addr,
    input  wire logic [31:0]          pc,
    output logic                      mem_req_valid,
    output mips_core_pkg::mem_req_t   mem_req,
    input  wire logic                 mem_req_ready,
    input  wire logic                 mem_rsp_valid,
    input  wire logic [31:0]          mem_rdata,
    output mips_isa_pkg::instr_t      instr,
    output logic                      advance,
    output logic                      we,
    output logic [4:0]                wr_addr,
    output logic [31:0]               wr_data
);

    mips_core_pkg::ctrl_state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_core_pkg::st_fetch;
        end else begin
            case (state)
                mips_core_pkg::st_fetch:
                    if (mem_req_ready) state <= mips_core_pkg::st_fetch_wait;
                mips_core_pkg::st_fetch_wait:
                    if (mem_rsp_valid) state <= mips_core_pkg::st_decode;
                mips_core_pkg::st_decode: state <= mips_core_pkg::st_exec;
                mips_core_pkg::st_exec:
                    if (dec.is_load || dec.is_store) state <= mips_core_pkg::st_mem;
                    else state <= mips_core_pkg::st_fetch;
                mips_core_pkg::st_mem:
                    if (mem_req_ready && dec.is_load) state <= mips_core_pkg::st_mem_wait;
                    else if (mem_req_ready) state <= mips_core_pkg::st_fetch; // stores
                mips_core_pkg::st_mem_wait:
                    if (mem_rsp_valid) state <= mips_core_pkg::st_fetch;
                default: state <= mips_core_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips_core_pkg::st_fetch_wait && mem_rsp_valid) begin
            instr <= mem_rdata;
        end
    end

    assign mem_req_valid = !reset
        && (state == mips_core_pkg::st_fetch || state == mips_core_pkg::st_mem);
    assign advance       = state == mips_core_pkg::st_exec;

    always_comb begin
        mem_req.addr  = pc;
        mem_req.write = 1'b0;
        mem_req.wdata = '0;
        if (state == mips_core_pkg::st_mem) begin
            mem_req.addr  = alu_result;
            mem_req.write = dec.is_store;
            mem_req.wdata = rt_data;
        end
    end

    // load data goes straight from the response into the register file
    assign we = (advance && dec.reg_write && !dec.is_load)
             || (state == mips_core_pkg::st_mem_wait && mem_rsp_valid);
    assign wr_addr = dec.write_reg;

    always_comb begin
        if (dec.is_link) wr_data = link_addr;
        else if (dec.is_load) wr_data = mem_rdata;
        else wr_data = alu_result;
    end

    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)));

endmodule

`default_nettype wire

// ==== verilog/mips_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu (
    input  wire logic               clk,
    input  wire logic               reset,
    output logic                    mem_req_valid,
    output mips_core_pkg::mem_req_t mem_req,
    input  wire logic               mem_req_ready,
    input  wire logic               mem_rsp_valid,
    input  wire logic [31:0]        mem_rdata
);

    mips_isa_pkg::instr_t          instr;
    mips_core_pkg::dec_t           dec;
    mips_core_pkg::branch_flags_t  flags;
    logic [31:0]                   rs_data;
    logic [31:0]                   rt_data;
    logic [31:0]                   alu_result;
    logic [31:0]                   link_addr;
    logic [31:0]                   pc;
    logic                          advance;
    logic                          we;
    logic [4:0]                    wr_addr;
    logic [31:0]                   wr_data;

    mips_cpu_control control_i (
        .clk, .reset, .dec, .alu_result, .rt_data, .link_addr, .pc,
        .mem_req_valid, .mem_req, .mem_req_ready, .mem_rsp_valid, .mem_rdata,
        .instr, .advance, .we, .wr_addr, .wr_data
    );

    mips_cpu_decode decode_i (.instr, .dec);

    mips_cpu_regfile regfile_i (
        .clk, .reset,
        .rs_addr (instr.r.rs),
        .rt_addr (instr.r.rt),
        .rs_data, .rt_data, .we, .wr_addr, .wr_data
    );

    mips_cpu_alu alu_i (
        .alu_op  (dec.alu_op),
        .use_imm (dec.use_imm),
        .rs_data, .rt_data,
        .imm     (instr.i.imm),
        .result  (alu_result),
        .flags
    );

    mips_cpu_pc pc_i (
        .clk, .reset, .advance, .instr,
        .pc_op       (dec.pc_op),
        .branch_cond (dec.branch_cond),
        .flags, .rs_data, .pc, .link_addr
    );

endmodule

`default_nettype wire

// ==== dv/mips_cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_tb;

    localparam logic [31:0] data_base = 32'h0000_1000;

    logic                    clk;
    logic                    reset;
    logic                    mem_req_valid;
    mips_core_pkg::mem_req_t mem_req;
    logic                    mem_req_ready;
    logic                    mem_rsp_valid;
    logic [31:0]             mem_rdata;

    logic [31:0] prog [128];
    logic [31:0] dmem [64];
    logic [31:0] m_data [64];   // model's own copy of the data region
    logic [31:0] m_regs [32];
    logic [31:0] m_pc, m_dest, exp_addr, exp_wdata, loop_addr, rsp_word;
    logic        m_delay, exp_fetch, exp_write, pending;
    logic [4:0]  load_reg;
    logic [1:0]  rsp_cnt;
    int          n, st_off, loop_hits, cycles, limit;
    integer      seed;

    mips_cpu dut_i (.clk, .reset, .mem_req_valid, .mem_req, .mem_req_ready,
        .mem_rsp_valid, .mem_rdata);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] addr_of(input int idx);
        return mips_isa_pkg::reset_vector + 32'(idx * 4);
    endfunction

    function automatic logic [31:0] r_ins(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_ins(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_ins(input logic [5:0] op, input logic [31:0] dst);
        return {op, dst[27:2]};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[n] = w;
        n++;
    endtask

    // branch over one skipped word, delay slot bumps r8, skipped word bumps r9
    task automatic branch3(input logic [31:0] w);
        emit(w);
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd8, 5'd8, 16'd1));
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd9, 5'd9, 16'd1));
    endtask

    task automatic store(input logic [4:0] rt);
        emit(i_ins(mips_isa_pkg::op_sw, 5'd1, rt, 16'(st_off)));
        st_off += 4;
    endtask

    task automatic build_program();
        n = 0;
        st_off = 16;
        for (int i = 0; i < 128; i++) prog[i] = 32'd0;
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd0, 5'd1, 16'h1000)); // data base
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd0, 5'd2, 16'd5));
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd0, 5'd3, 16'hfffd));
        emit(r_ins(mips_isa_pkg::fn_addu, 5'd2, 5'd3, 5'd4));
        emit(r_ins(mips_isa_pkg::fn_subu, 5'd3, 5'd2, 5'd5));
        emit(i_ins(mips_isa_pkg::op_lui, 5'd0, 5'd6, 16'h1234));
        emit(i_ins(mips_isa_pkg::op_sw, 5'd1, 5'd4, 16'd0));
        emit(i_ins(mips_isa_pkg::op_sw, 5'd1, 5'd5, 16'd4));
        emit(i_ins(mips_isa_pkg::op_sw, 5'd1, 5'd6, 16'd8));
        emit(i_ins(mips_isa_pkg::op_lw, 5'd1, 5'd7, 16'd8));
        emit(i_ins(mips_isa_pkg::op_sw, 5'd1, 5'd7, 16'd12));
        branch3(i_ins(mips_isa_pkg::op_beq, 5'd2, 5'd2, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_beq, 5'd2, 5'd3, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_bne, 5'd2, 5'd3, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_bne, 5'd2, 5'd2, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_bgtz, 5'd2, 5'd0, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_bgtz, 5'd3, 5'd0, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_blez, 5'd3, 5'd0, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_blez, 5'd2, 5'd0, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_blez, 5'd0, 5'd0, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd3, mips_isa_pkg::rt_bltz, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd2, mips_isa_pkg::rt_bltz, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd2, mips_isa_pkg::rt_bgez, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd3, mips_isa_pkg::rt_bgez, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd0, mips_isa_pkg::rt_bgez, 16'd2));
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd3, mips_isa_pkg::rt_bltzal, 16'd2));
        store(5'd31);
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd2, mips_isa_pkg::rt_bltzal, 16'd2));
        store(5'd31);
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd2, mips_isa_pkg::rt_bgezal, 16'd2));
        store(5'd31);
        branch3(i_ins(mips_isa_pkg::op_regimm, 5'd3, mips_isa_pkg::rt_bgezal, 16'd2));
        store(5'd31);
        branch3(j_ins(mips_isa_pkg::op_j, addr_of(n + 3)));
        branch3(j_ins(mips_isa_pkg::op_jal, addr_of(n + 3)));
        store(5'd31);
        emit(i_ins(mips_isa_pkg::op_lui, 5'd0, 5'd10, 16'hbfc0));
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd10, 5'd10, 16'(addr_of(n + 4))));
        branch3(r_ins(mips_isa_pkg::fn_jr, 5'd10, 5'd0, 5'd0));
        emit(i_ins(mips_isa_pkg::op_lui, 5'd0, 5'd10, 16'hbfc0));
        emit(i_ins(mips_isa_pkg::op_addiu, 5'd10, 5'd10, 16'(addr_of(n + 4))));
        branch3(r_ins(mips_isa_pkg::fn_jalr, 5'd10, 5'd0, 5'd11));
        store(5'd11);
        store(5'd8);
        store(5'd9);
        loop_addr = addr_of(n);
        emit(j_ins(mips_isa_pkg::op_j, loop_addr)); // final loop with a nop in its delay slot
        emit(32'd0);
        limit = n * 5 * 4 * 2;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // executes one instruction on each accepted fetch, one data access otherwise
    task automatic model_step();
        logic [31:0] w, a, b, simm, wval;
        logic [31:0] pc4;
        logic [4:0]  wreg;
        logic        wr, xfer;
        if (!exp_fetch) begin
            if (exp_write) m_data[exp_addr[7:2]] = exp_wdata;
            else m_regs[load_reg] = m_data[exp_addr[7:2]];
            exp_fetch = 1'b1;
            exp_write = 1'b0;
            exp_addr  = m_pc;
        end else begin
            if (m_pc == loop_addr) loop_hits++;
            w    = prog[m_pc[8:2]];
            a    = m_regs[w[25:21]];
            b    = m_regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            pc4  = m_pc + 32'd4;
            wr   = 1'b0;
            wreg = w[20:16];
            wval = 32'd0;
            xfer = 1'b0;
            m_dest = m_delay ? m_dest : pc4 + (simm << 2);
            case (w[31:26])
                6'h00: begin
                    wreg = w[15:11];
                    case (w[5:0])
                        6'h21: {wr, wval} = {1'b1, a + b};
                        6'h23: {wr, wval} = {1'b1, a - b};
                        6'h08: {xfer, m_dest} = {1'b1, a};
                        6'h09: begin
                            {xfer, m_dest} = {1'b1, a};
                            {wr, wval} = {1'b1, m_pc + 32'd8};
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'h01: begin
                    xfer = w[16] ? !a[31] : a[31]; // rt bit 0 picks gez
                    wreg = 5'd31;
                    {wr, wval} = {w[20], m_pc + 32'd8};
                end
                6'h02, 6'h03: begin
                    xfer   = 1'b1;
                    m_dest = {pc4[31:28], w[25:0], 2'b00};
                    wreg   = 5'd31;
                    {wr, wval} = {w[26], m_pc + 32'd8};
                end
                6'h04: xfer = a == b;
                6'h05: xfer = a != b;
                6'h06: xfer = $signed(a) <= 0;
                6'h07: xfer = $signed(a) > 0;
                6'h09: {wr, wval} = {1'b1, a + simm};
                6'h0f: {wr, wval} = {1'b1, w[15:0], 16'h0000};
                6'h23, 6'h2b: begin
                    exp_fetch = 1'b0;
                    exp_write = w[31:26] == 6'h2b;
                    exp_addr  = a + simm;
                    exp_wdata = b;
                    load_reg  = w[20:16];
                end
                default: wr = 1'b0;
            endcase
            if (wr && wreg != 5'd0) m_regs[wreg] = wval;
            if (xfer) begin
                m_pc    = m_pc + 32'd4;
                m_delay = 1'b1;
            end else if (m_delay) begin
                m_pc    = m_dest;
                m_delay = 1'b0;
            end else begin
                m_pc = m_pc + 32'd4;
            end
            if (exp_fetch) exp_addr = m_pc;
        end
    endtask

    initial begin
        seed          = 32'h2f5e_b9e5;
        reset         = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = 32'd0;
        pending       = 1'b0;
        rsp_cnt       = 2'd0;
        rsp_word      = 32'd0;
        loop_hits     = 0;
        cycles        = 0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]   = (data_base + 32'(i * 4)) * 32'h9e37_79b9 ^ 32'h5a5a_0000;
            m_data[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) m_regs[i] = 32'd0;
        m_pc      = mips_isa_pkg::reset_vector;
        m_dest    = 32'd0;
        m_delay   = 1'b0;
        exp_fetch = 1'b1;
        exp_write = 1'b0;
        exp_addr  = mips_isa_pkg::reset_vector;
        exp_wdata = 32'd0;
        load_reg  = 5'd0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    // random ready and a 1 to 4 cycle read latency
    always @(posedge clk) begin
        if (!reset) begin
            mem_req_ready <= ($random(seed) & 3) != 0;
            mem_rsp_valid <= 1'b0;
            if (pending && rsp_cnt == 2'd0) begin
                mem_rsp_valid <= 1'b1;
                mem_rdata     <= rsp_word;
                pending       <= 1'b0;
            end else if (pending) begin
                rsp_cnt <= rsp_cnt - 2'd1;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.addr[31:9] == mips_isa_pkg::reset_vector[31:9] && !mem_req.write) begin
                    rsp_word <= prog[mem_req.addr[8:2]];
                end else if (mem_req.addr[31:8] == data_base[31:8]) begin
                    rsp_word <= dmem[mem_req.addr[7:2]];
                    if (mem_req.write) dmem[mem_req.addr[7:2]] <= mem_req.wdata;
                end else begin
                    report_failure("memory request outside the program and data regions");
                end
                pending <= !mem_req.write;
                rsp_cnt <= 2'($random(seed) & 3);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && mem_req_valid && mem_req_ready) begin
            model_step();
            if (loop_hits == 2) begin
                $display("TEST PASSED");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == limit + 5) begin
            $display("program did not reach its final loop within %0d cycles", limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    addr_a: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && mem_req_ready) |-> mem_req.addr == exp_addr)
        else report_failure($sformatf("** Error request address: expected %h, actual %h",
            $sampled(exp_addr), $sampled(mem_req.addr)));

    write_a: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && mem_req_ready) |-> mem_req.write == exp_write)
        else report_failure($sformatf("** Error request write flag: expected %b, actual %b",
            $sampled(exp_write), $sampled(mem_req.write)));

    wdata_a: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && mem_req_ready && exp_write) |-> mem_req.wdata == exp_wdata)
        else report_failure($sformatf("** Error store data: expected %h, actual %h",
            $sampled(exp_wdata), $sampled(mem_req.wdata)));

    hold_a: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else report_failure("memory request changed or dropped while waiting for ready");

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/mips_isa_pkg.sv
verilog/mips_core_pkg.sv
verilog/mips_cpu_pc.sv
verilog/mips_cpu_decode.sv
verilog/mips_cpu_regfile.sv
verilog/mips_cpu_alu.sv
verilog/mips_cpu_control.sv
verilog/mips_cpu.sv
dv/mips_cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mips_cpu testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert \
        --top-module mips_cpu_tb \
        -f filelist.f \
        --Mdir obj_dir -o mips_cpu_tb; then
    echo "compile failed"
    exit 1
fi

./obj_dir/mips_cpu_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
